//--- compile.f
src/regbridge_pkg.sv
src/cmd_decoder.sv
src/reg_executor.sv
src/rsp_formatter.sv
src/usb_reg_bridge_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the register bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f compile.f -Mdir obj_dir -o sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- testbench/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    import regbridge_pkg::*;

    localparam int LOCAL_WORDS = LOCAL_WORDS_DEF;
    localparam int N_CMDS      = 400;

    logic      regACLK;
    logic      i_rst_n;
    logic      i_rx_valid;
    byte_t     i_rx_data;
    logic      o_rx_ready;
    logic      o_ext_req_valid;
    reg_req_t  o_ext_req;
    logic      i_ext_req_ready;
    logic      i_ext_rsp_valid;
    resp_t     i_ext_rsp_resp;
    reg_data_t i_ext_rsp_rdata;
    logic      o_ext_rsp_ready;
    logic      o_tx_valid;
    reg_data_t o_tx_data;
    resp_t     o_tx_resp;
    logic      i_tx_ready;

    logic      stim_done;
    logic      end_req;
    logic      chk_timeout;
    logic      chk_done;
    int        tx_count;
    int        err_total;
    byte_t     rx_bytes[$];                 // Whole RX byte stream
    reg_data_t slave_mem [reg_addr_t];      // External register slave storage

    initial regACLK = 1'b0;
    always #4 regACLK = ~regACLK;           // 8 ns period

    usb_reg_bridge_top #(
        .LOCAL_WORDS (LOCAL_WORDS)
    ) u_dut (
        .regACLK         (regACLK),
        .i_rst_n         (i_rst_n),
        .i_rx_valid      (i_rx_valid),
        .i_rx_data       (i_rx_data),
        .o_rx_ready      (o_rx_ready),
        .o_ext_req_valid (o_ext_req_valid),
        .o_ext_req       (o_ext_req),
        .i_ext_req_ready (i_ext_req_ready),
        .i_ext_rsp_valid (i_ext_rsp_valid),
        .i_ext_rsp_resp  (i_ext_rsp_resp),
        .i_ext_rsp_rdata (i_ext_rsp_rdata),
        .o_ext_rsp_ready (o_ext_rsp_ready),
        .o_tx_valid      (o_tx_valid),
        .o_tx_data       (o_tx_data),
        .o_tx_resp       (o_tx_resp),
        .i_tx_ready      (i_tx_ready)
    );

    tb_checker #(
        .LOCAL_WORDS (LOCAL_WORDS),
        .N_CMDS      (N_CMDS)
    ) u_check (
        .regACLK    (regACLK),
        .i_rst_n    (i_rst_n),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .i_rx_ready (o_rx_ready),
        .i_tx_valid (o_tx_valid),
        .i_tx_data  (o_tx_data),
        .i_tx_resp  (o_tx_resp),
        .i_tx_ready (i_tx_ready),
        .i_end_req  (end_req),
        .o_timeout  (chk_timeout),
        .o_done     (chk_done),
        .o_tx_count (tx_count),
        .o_errors   (err_total)
    );

    // ==============================
    // Command stream
    // ==============================

    task automatic build_commands();
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
        byte_t     junk;
        for (int n = 0; n < N_CMDS; n++) begin
            if ($urandom % 16 == 0) begin
                junk = byte_t'($urandom);
                while (junk == OPC_REG_WRITE || junk == OPC_REG_READ) begin
                    junk = byte_t'($urandom);
                end
                rx_bytes.push_back(junk);
            end
            wr = 1'($urandom);
            if ($urandom % 2 == 0) begin
                addr = reg_addr_t'($urandom % (LOCAL_WORDS * 4));
            end else begin
                addr = reg_addr_t'(LOCAL_WORDS * 4 + ($urandom % 16) * 4);   // Aliases low words
                if ($urandom % 4 == 0) addr[14] = 1'b1;                    // Slave error range
            end
            data = $urandom;
            rx_bytes.push_back(wr ? OPC_REG_WRITE : OPC_REG_READ);
            rx_bytes.push_back({1'($urandom), addr[14:8]});   // Top bit lies outside the map
            rx_bytes.push_back(addr[7:0]);
            if (wr) begin
                rx_bytes.push_back(data[31:24]);
                rx_bytes.push_back(data[23:16]);
                rx_bytes.push_back(data[15:8]);
                rx_bytes.push_back(data[7:0]);
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input byte_t b);
        while ($urandom % 4 == 0) begin
            i_rx_valid = 1'b0;   // Random gap
            @(negedge regACLK);
        end
        i_rx_valid = 1'b1;
        i_rx_data  = b;
        while (!o_rx_ready) @(negedge regACLK);
        @(negedge regACLK);
    endtask

    initial begin : stimulus
        void'($urandom(32'h8585cfc1));
        i_rst_n         = 1'b0;
        i_rx_valid      = 1'b0;
        i_rx_data       = '0;
        i_ext_req_ready = 1'b0;
        i_ext_rsp_valid = 1'b0;
        i_ext_rsp_resp  = RESP_OKAY;
        i_ext_rsp_rdata = '0;
        i_tx_ready      = 1'b0;
        stim_done       = 1'b0;
        end_req         = 1'b0;
        build_commands();
        repeat (3) @(posedge regACLK);
        @(negedge regACLK);
        i_rst_n = 1'b1;
        foreach (rx_bytes[i]) send_byte(rx_bytes[i]);
        i_rx_valid = 1'b0;
        stim_done  = 1'b1;
    end

    // TX sink with random stalls
    always @(negedge regACLK) i_tx_ready = ($urandom % 4 != 0);

    // ==============================
    // External register slave
    // ==============================

    initial begin : ext_slave
        reg_req_t req;
        int       delay;
        wait (i_rst_n === 1'b1);
        forever begin
            @(negedge regACLK);
            if (o_ext_req_valid) begin
                delay = int'($urandom % 7);
                repeat (delay) @(negedge regACLK);
                req             = o_ext_req;
                i_ext_req_ready = 1'b1;
                @(negedge regACLK);
                i_ext_req_ready = 1'b0;
                i_ext_rsp_resp  = req.addr[14] ? RESP_SLVERR : RESP_OKAY;
                i_ext_rsp_rdata = '0;
                if (req.is_write) begin
                    i_ext_rsp_rdata = $urandom;   // Noise the bridge must drop
                    if (!req.addr[14]) slave_mem[req.addr] = req.wdata;
                end else if (!req.addr[14] && slave_mem.exists(req.addr)) begin
                    i_ext_rsp_rdata = slave_mem[req.addr];
                end
                delay = int'($urandom % 7);
                repeat (delay) @(negedge regACLK);
                i_ext_rsp_valid = 1'b1;
                while (!o_ext_rsp_ready) @(negedge regACLK);
                @(negedge regACLK);
                i_ext_rsp_valid = 1'b0;
            end
        end
    end

    // End of run
    initial begin : finish_run
        wait (i_rst_n === 1'b1);
        while (!(stim_done && tx_count >= N_CMDS) && !chk_timeout) @(negedge regACLK);
        if (!chk_timeout) repeat (20) @(negedge regACLK);   // Room for stray words
        end_req = 1'b1;
        while (!chk_done) @(negedge regACLK);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
    parameter int LOCAL_WORDS = regbridge_pkg::LOCAL_WORDS_DEF,
    parameter int N_CMDS      = 400
) (
    input  logic                     regACLK,
    input  logic                     i_rst_n,
    input  logic                     i_rx_valid,
    input  regbridge_pkg::byte_t     i_rx_data,
    input  logic                     i_rx_ready,
    input  logic                     i_tx_valid,
    input  regbridge_pkg::reg_data_t i_tx_data,
    input  regbridge_pkg::resp_t     i_tx_resp,
    input  logic                     i_tx_ready,
    input  logic                     i_end_req,
    output logic                     o_timeout,
    output logic                     o_done,
    output int                       o_tx_count,
    output int                       o_errors
);

    import regbridge_pkg::*;

    localparam int MAX_CYCLES = N_CMDS * 40;

    // One expected TX word, in command order
    typedef struct packed {
        logic [15:0] idx;
        logic        is_write;
        reg_addr_t   addr;
        reg_data_t   data;
        resp_t       resp;
    } expect_t;

    expect_t   pending[$];
    reg_data_t loc_regs [LOCAL_WORDS];
    reg_data_t ext_regs [reg_addr_t];

    int        phase;       // 0 opcode, 1 and 2 address, 3 to 6 data
    logic      cur_write;
    reg_addr_t cur_addr;
    reg_data_t cur_data;
    int        cmd_count;
    int        cycles;
    int        err_data;
    int        err_resp;
    int        err_count;
    int        err_timeout;

    // Reference behavior of both register spaces
    task automatic record_command();
        expect_t e;
        e.idx      = 16'(cmd_count);
        e.is_write = cur_write;
        e.addr     = cur_addr;
        e.data     = '0;
        e.resp     = RESP_OKAY;
        if (cur_addr < reg_addr_t'(LOCAL_WORDS * 4)) begin
            if (cur_write) loc_regs[cur_addr >> 2] = cur_data;
            else e.data = loc_regs[cur_addr >> 2];
        end else if (cur_addr[14]) begin
            e.resp = RESP_SLVERR;
        end else if (cur_write) begin
            ext_regs[cur_addr] = cur_data;
        end else if (ext_regs.exists(cur_addr)) begin
            e.data = ext_regs[cur_addr];
        end
        pending.push_back(e);
        cmd_count++;
    endtask

    // ==============================
    // Watch and compare
    // ==============================

    always @(posedge regACLK) begin : watch
        expect_t e;
        if (!i_rst_n) begin
            phase       = 0;
            cmd_count   = 0;
            cycles      = 0;
            err_data    = 0;
            err_resp    = 0;
            err_count   = 0;
            err_timeout = 0;
            pending.delete();
            for (int i = 0; i < LOCAL_WORDS; i++) loc_regs[i] = '0;
            o_timeout  <= 1'b0;
            o_done     <= 1'b0;
            o_tx_count <= 0;
            o_errors   <= 0;
        end else begin
            if (i_tx_valid && i_tx_ready) begin
                o_tx_count <= o_tx_count + 1;
                if (pending.size() == 0) begin
                    err_count++;
                    $display("Extra TX word %h at %0t with no command outstanding",
                             i_tx_data, $time);
                end else begin
                    e = pending.pop_front();
                    if (i_tx_data !== e.data) err_data++;
                    if (i_tx_resp !== e.resp) err_resp++;
                    if (i_tx_data !== e.data || i_tx_resp !== e.resp) begin
                        $display("ERR %0t: cmd %0d %s addr %h exp %h/%0d got %h/%0d",
                                 $time, e.idx, e.is_write ? "write" : "read", e.addr,
                                 e.data, e.resp, i_tx_data, i_tx_resp);
                    end
                end
            end
            if (i_rx_valid && i_rx_ready) begin
                case (phase)
                    0: begin
                        if (i_rx_data == OPC_REG_WRITE || i_rx_data == OPC_REG_READ) begin
                            cur_write = (i_rx_data == OPC_REG_WRITE);
                            cur_data  = '0;
                            phase     = 1;
                        end
                    end
                    1: begin
                        cur_addr[14:8] = i_rx_data[6:0];
                        phase          = 2;
                    end
                    2: begin
                        cur_addr[7:0] = i_rx_data;
                        if (cur_write) begin
                            phase = 3;
                        end else begin
                            record_command();
                            phase = 0;
                        end
                    end
                    default: begin
                        cur_data = {cur_data[23:0], i_rx_data};   // MSB first
                        if (phase == 6) begin
                            record_command();
                            phase = 0;
                        end else begin
                            phase++;
                        end
                    end
                endcase
            end
            cycles++;
            if (cycles == MAX_CYCLES) begin
                err_timeout++;
                $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                o_timeout <= 1'b1;
            end
            if (i_end_req && !o_done) begin
                if (pending.size() != 0) begin
                    err_count += pending.size();
                    $display("%0d expected responses never came out on TX", pending.size());
                end else begin
                    $display("Response queue is empty at the end of the run");
                end
                if (cmd_count != N_CMDS) begin
                    err_count++;
                    $display("Decoded %0d commands from RX but %0d were sent", cmd_count, N_CMDS);
                end
                $display("Errors: data %0d, resp %0d, count %0d, timeout %0d",
                         err_data, err_resp, err_count, err_timeout);
                o_errors <= err_data + err_resp + err_count + err_timeout;
                o_done   <= 1'b1;
            end
        end
    end

endmodule

//--- src/usb_reg_bridge_top.sv
`timescale 1ns/10ps

module usb_reg_bridge_top #(
    parameter int LOCAL_WORDS = regbridge_pkg::LOCAL_WORDS_DEF
) (
    input  logic                     regACLK,
    input  logic                     i_rst_n,
    // RX byte stream
    input  logic                     i_rx_valid,
    input  regbridge_pkg::byte_t     i_rx_data,
    output logic                     o_rx_ready,
    // External register port
    output logic                     o_ext_req_valid,
    output regbridge_pkg::reg_req_t  o_ext_req,
    input  logic                     i_ext_req_ready,
    input  logic                     i_ext_rsp_valid,
    input  regbridge_pkg::resp_t     i_ext_rsp_resp,
    input  regbridge_pkg::reg_data_t i_ext_rsp_rdata,
    output logic                     o_ext_rsp_ready,
    // TX word stream
    output logic                     o_tx_valid,
    output regbridge_pkg::reg_data_t o_tx_data,
    output regbridge_pkg::resp_t     o_tx_resp,
    input  logic                     i_tx_ready
);

    import regbridge_pkg::*;

    reg_req_t req;
    logic     req_valid;
    logic     req_ready;
    reg_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;

    // ==============================
    // Pipeline stages
    // ==============================

    cmd_decoder u_decode (
        .regACLK     (regACLK),
        .i_rst_n     (i_rst_n),
        .i_rx_valid  (i_rx_valid),
        .i_rx_data   (i_rx_data),
        .o_rx_ready  (o_rx_ready),
        .o_req_valid (req_valid),
        .o_req       (req),
        .i_req_ready (req_ready)
    );

    reg_executor #(
        .LOCAL_WORDS (LOCAL_WORDS)
    ) u_execute (
        .regACLK         (regACLK),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (req_valid),
        .i_req           (req),
        .o_req_ready     (req_ready),
        .o_ext_req_valid (o_ext_req_valid),
        .o_ext_req       (o_ext_req),
        .i_ext_req_ready (i_ext_req_ready),
        .i_ext_rsp_valid (i_ext_rsp_valid),
        .i_ext_rsp_resp  (i_ext_rsp_resp),
        .i_ext_rsp_rdata (i_ext_rsp_rdata),
        .o_ext_rsp_ready (o_ext_rsp_ready),
        .o_rsp_valid     (rsp_valid),
        .o_rsp           (rsp),
        .i_rsp_ready     (rsp_ready)
    );

    rsp_formatter u_result (
        .regACLK     (regACLK),
        .i_rst_n     (i_rst_n),
        .i_rsp_valid (rsp_valid),
        .i_rsp       (rsp),
        .o_rsp_ready (rsp_ready),
        .o_tx_valid  (o_tx_valid),
        .o_tx_data   (o_tx_data),
        .o_tx_resp   (o_tx_resp),
        .i_tx_ready  (i_tx_ready)
    );

endmodule

//--- src/rsp_formatter.sv
`timescale 1ns/10ps

module rsp_formatter (
    input  logic                     regACLK,
    input  logic                     i_rst_n,
    input  logic                     i_rsp_valid,
    input  regbridge_pkg::reg_rsp_t  i_rsp,
    output logic                     o_rsp_ready,
    output logic                     o_tx_valid,
    output regbridge_pkg::reg_data_t o_tx_data,
    output regbridge_pkg::resp_t     o_tx_resp,
    input  logic                     i_tx_ready
);

    import regbridge_pkg::*;

    logic      tx_valid_q;
    reg_data_t tx_data_q;
    resp_t     tx_resp_q;
    logic      rsp_fire;

    // Free when empty or when the held word leaves this cycle
    assign o_rsp_ready = !tx_valid_q || i_tx_ready;
    assign rsp_fire    = i_rsp_valid && o_rsp_ready;

    assign o_tx_valid = tx_valid_q;
    assign o_tx_data  = tx_data_q;
    assign o_tx_resp  = tx_resp_q;

    always_ff @(posedge regACLK) begin
        if (!i_rst_n) begin
            tx_valid_q <= 1'b0;
        end else if (rsp_fire) begin
            tx_valid_q <= 1'b1;
        end else if (i_tx_ready) begin
            tx_valid_q <= 1'b0;
        end
    end

    // Writes report a zero output word
    always_ff @(posedge regACLK) begin
        if (rsp_fire) begin
            tx_data_q <= i_rsp.is_write ? '0 : i_rsp.rdata;
            tx_resp_q <= i_rsp.resp;
        end
    end

endmodule

//--- src/reg_executor.sv
`timescale 1ns/10ps

module reg_executor #(
    parameter int LOCAL_WORDS = regbridge_pkg::LOCAL_WORDS_DEF
) (
    input  logic                     regACLK,
    input  logic                     i_rst_n,
    input  logic                     i_req_valid,
    input  regbridge_pkg::reg_req_t  i_req,
    output logic                     o_req_ready,
    output logic                     o_ext_req_valid,
    output regbridge_pkg::reg_req_t  o_ext_req,
    input  logic                     i_ext_req_ready,
    input  logic                     i_ext_rsp_valid,
    input  regbridge_pkg::resp_t     i_ext_rsp_resp,
    input  regbridge_pkg::reg_data_t i_ext_rsp_rdata,
    output logic                     o_ext_rsp_ready,
    output logic                     o_rsp_valid,
    output regbridge_pkg::reg_rsp_t  o_rsp,
    input  logic                     i_rsp_ready
);

    import regbridge_pkg::*;

    localparam int        IDX_W       = $clog2(LOCAL_WORDS);
    localparam reg_addr_t LOCAL_LIMIT = reg_addr_t'(LOCAL_WORDS * 4);   // First external byte address

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOCAL,      // Local result ready
        S_EXT_REQ,
        S_EXT_WAIT,
        S_RSP         // External result ready
    } exe_state_t;

    exe_state_t state;
    reg_req_t   req_q;
    reg_rsp_t   rsp_q;
    reg_data_t  bank [LOCAL_WORDS];

    logic             req_fire;
    logic             is_local;
    logic [IDX_W-1:0] idx;

    assign o_req_ready     = (state == S_IDLE);
    assign req_fire        = i_req_valid && o_req_ready;
    assign is_local        = (i_req.addr < LOCAL_LIMIT);
    assign idx             = i_req.addr[IDX_W+1:2];   // Word index
    assign o_ext_req_valid = (state == S_EXT_REQ);
    assign o_ext_req       = req_q;
    assign o_ext_rsp_ready = (state == S_EXT_WAIT);
    assign o_rsp_valid     = (state == S_LOCAL) || (state == S_RSP);
    assign o_rsp           = rsp_q;

    // ==============================
    // Access sequencing
    // ==============================

    always_ff @(posedge regACLK) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            for (int i = 0; i < LOCAL_WORDS; i++) begin
                bank[i] <= '0;
            end
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_fire) begin
                        state <= is_local ? S_LOCAL : S_EXT_REQ;
                        if (is_local && i_req.is_write) bank[idx] <= i_req.wdata;
                    end
                end
                S_EXT_REQ:  if (i_ext_req_ready) state <= S_EXT_WAIT;
                S_EXT_WAIT: if (i_ext_rsp_valid) state <= S_RSP;
                S_LOCAL, S_RSP: begin
                    if (i_rsp_ready) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request copy and response word
    always_ff @(posedge regACLK) begin
        if (req_fire) begin
            req_q          <= i_req;
            rsp_q.is_write <= i_req.is_write;
            rsp_q.resp     <= RESP_OKAY;   // Local accesses never fail
            rsp_q.rdata    <= i_req.is_write ? '0 : bank[idx];
        end else if (state == S_EXT_WAIT && i_ext_rsp_valid) begin
            rsp_q.is_write <= req_q.is_write;
            rsp_q.resp     <= i_ext_rsp_resp;
            rsp_q.rdata    <= req_q.is_write ? '0 : i_ext_rsp_rdata;
        end
    end

endmodule

//--- src/cmd_decoder.sv
`timescale 1ns/10ps

module cmd_decoder (
    input  logic                    regACLK,
    input  logic                    i_rst_n,
    input  logic                    i_rx_valid,
    input  regbridge_pkg::byte_t    i_rx_data,
    output logic                    o_rx_ready,
    output logic                    o_req_valid,
    output regbridge_pkg::reg_req_t o_req,
    input  logic                    i_req_ready
);

    import regbridge_pkg::*;

    typedef enum logic [2:0] {
        ST_OPC,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_DATA0,
        ST_DATA1,
        ST_DATA2,
        ST_DATA3,
        ST_HOLD
    } dec_state_t;

    dec_state_t state;
    reg_req_t   req_q;
    logic       rx_fire;

    // RX stalls while a finished request waits for the executor
    assign o_rx_ready  = (state != ST_HOLD);
    assign rx_fire     = i_rx_valid && o_rx_ready;
    assign o_req_valid = (state == ST_HOLD);
    assign o_req       = req_q;

    // ==============================
    // Byte sequencing
    // ==============================

    always_ff @(posedge regACLK) begin
        if (!i_rst_n) begin
            state <= ST_OPC;
        end else begin
            case (state)
                ST_OPC: begin
                    // Unknown opcodes are swallowed here
                    if (rx_fire && (i_rx_data == OPC_REG_WRITE || i_rx_data == OPC_REG_READ)) begin
                        state <= ST_ADDR_HI;
                    end
                end
                ST_ADDR_HI: if (rx_fire) state <= ST_ADDR_LO;
                ST_ADDR_LO: begin
                    if (rx_fire) begin
                        state <= req_q.is_write ? ST_DATA0 : ST_HOLD;
                    end
                end
                ST_DATA0:   if (rx_fire) state <= ST_DATA1;
                ST_DATA1:   if (rx_fire) state <= ST_DATA2;
                ST_DATA2:   if (rx_fire) state <= ST_DATA3;
                ST_DATA3:   if (rx_fire) state <= ST_HOLD;
                ST_HOLD:    if (i_req_ready) state <= ST_OPC;
                default:    state <= ST_OPC;
            endcase
        end
    end

    // Request fields, filled byte by byte
    always_ff @(posedge regACLK) begin
        if (rx_fire) begin
            case (state)
                ST_OPC: begin
                    req_q.is_write <= (i_rx_data == OPC_REG_WRITE);
                    req_q.wdata    <= '0;
                end
                ST_ADDR_HI: req_q.addr[14:8] <= i_rx_data[6:0];   // Top bit is outside the 15-bit map
                ST_ADDR_LO: req_q.addr[7:0]  <= i_rx_data;
                ST_DATA0, ST_DATA1, ST_DATA2, ST_DATA3: begin
                    req_q.wdata <= {req_q.wdata[23:0], i_rx_data};   // MSB first
                end
                default: ;
            endcase
        end
    end

endmodule

//--- src/regbridge_pkg.sv
package regbridge_pkg;

    // ==============================
    // Basic widths
    // ==============================

    typedef logic [14:0] reg_addr_t;   // Register byte address
    typedef logic [31:0] reg_data_t;   // Register data word
    typedef logic [1:0]  resp_t;       // Response code in AXI encoding
    typedef logic [7:0]  byte_t;       // One RX stream byte

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // ==============================
    // Command opcodes
    // ==============================

    localparam byte_t OPC_REG_WRITE = 8'h02;   // addr hi, addr lo, 4 data bytes MSB first
    localparam byte_t OPC_REG_READ  = 8'h03;   // addr hi, addr lo

    // Number of local control registers
    localparam int LOCAL_WORDS_DEF = 32;

    // ==============================
    // Request and response words
    // ==============================

    // Decoded register access in 48 bits
    typedef struct packed {
        logic      is_write;
        reg_addr_t addr;
        reg_data_t wdata;   // Zero for reads
    } reg_req_t;

    // Result of one access in 35 bits
    typedef struct packed {
        logic      is_write;
        resp_t     resp;
        reg_data_t rdata;   // Zero for writes
    } reg_rsp_t;

endpackage
